/* rtl/ciPkg.sv */
`default_nettype none

package ciPkg;

  localparam int ciWordWidth = 32;

  localparam int resetHoldBits = 5;  // core runs once the top bit sets.

  // system clock cycles in one microsecond.
  localparam int delayTickCycles = 75;
  localparam int delayTickBits = $clog2(delayTickCycles);

  localparam int profileCounterCount = 3;
  localparam int profileCycleIndex = 0;
  localparam int profileStallIndex = 1;
  localparam int profileIdleIndex = 2;

  // custom instruction numbers as seen on ciN.
  typedef enum logic [7:0] {
    opSwapByte = 8'd1,
    opDelay    = 8'd6,
    opProfile  = 8'd12
  } ciOpcode;

endpackage

`default_nettype wire

/* rtl/ciUnitIf.sv */
`default_nettype none

interface ciUnitIf import ciPkg::*; ();

  logic                   start;   // one-cycle strobe for this unit only.
  logic [ciWordWidth-1:0] dataA;
  logic [ciWordWidth-1:0] dataB;
  logic                   done;    // one-cycle strobe.
  logic [ciWordWidth-1:0] result;  // zero unless done.

  modport dispatcher (
    output start, dataA, dataB,
    input  done, result
  );

  modport unit (
    input  start, dataA, dataB,
    output done, result
  );

endinterface

`default_nettype wire

/* rtl/resetSequencer.sv */
`default_nettype none

module resetSequencer import ciPkg::*; (
  input  logic s_systemClock,
  input  logic s_pllLocked,
  output logic coreRunning,
  output logic peripheralRelease
);

  logic [resetHoldBits-1:0] holdCount;
  logic                     holdDone;

  assign holdDone = holdCount[resetHoldBits-1];

  // counts up after lock and then sticks.
  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      holdCount <= '0;
    end else if (!holdDone) begin
      holdCount <= holdCount + resetHoldBits'(1);
    end
  end

  assign coreRunning = holdDone;
  assign peripheralRelease = holdDone;  // released together with the core.

  // once running, only a loss of lock may stop the core.
  coreStaysRunning: assert property (
    @(posedge s_systemClock) disable iff (!s_pllLocked)
    coreRunning |=> coreRunning
  );

endmodule

`default_nettype wire

/* rtl/ciDispatcher.sv */
`default_nettype none

module ciDispatcher import ciPkg::*; (
  input  logic                   s_systemClock,
  input  logic                   coreRunning,
  input  logic                   ciStart,
  input  ciOpcode                ciN,
  input  logic [ciWordWidth-1:0] ciDataA,
  input  logic [ciWordWidth-1:0] ciDataB,
  ciUnitIf.dispatcher            delayPort,
  ciUnitIf.dispatcher            profilePort,
  output logic                   ciDone,
  output logic [ciWordWidth-1:0] ciResult
);

  logic                   startGated;
  logic                   swapSelect;
  logic                   delaySelect;
  logic                   profileSelect;
  logic                   swapDone;
  logic [ciWordWidth-1:0] swapValue;
  logic [ciWordWidth-1:0] swapResult;

  assign startGated = ciStart & coreRunning;  // no instructions before release.

  // single decode point for all units.
  always_comb begin
    swapSelect = 1'b0;
    delaySelect = 1'b0;
    profileSelect = 1'b0;
    case (ciN)
      opSwapByte: swapSelect = 1'b1;
      opDelay:    delaySelect = 1'b1;
      opProfile:  profileSelect = 1'b1;
      default:    ;  // unknown numbers never complete.
    endcase
  end

  assign delayPort.start = startGated & delaySelect;
  assign delayPort.dataA = ciDataA;
  assign delayPort.dataB = ciDataB;

  assign profilePort.start = startGated & profileSelect;
  assign profilePort.dataA = ciDataA;
  assign profilePort.dataB = ciDataB;

  // byte swap is ready in the start cycle.
  always_comb begin
    if (ciDataB[0]) begin
      // swap inside each half-word.
      swapValue = {ciDataA[23:16], ciDataA[31:24], ciDataA[7:0], ciDataA[15:8]};
    end else begin
      swapValue = {ciDataA[7:0], ciDataA[15:8], ciDataA[23:16], ciDataA[31:24]};
    end
  end

  assign swapDone = startGated & swapSelect;
  assign swapResult = swapDone ? swapValue : '0;

  // wired-OR of all completion sources.
  assign ciDone = swapDone | delayPort.done | profilePort.done;
  assign ciResult = swapResult | delayPort.result | profilePort.result;

  // the OR only works if at most one source answers at a time.
  singleDoneSource: assert property (
    @(posedge s_systemClock) disable iff (!coreRunning)
    $onehot0({swapDone, delayPort.done, profilePort.done})
  );

endmodule

`default_nettype wire

/* rtl/delayUnit.sv */
`default_nettype none

module delayUnit import ciPkg::*; (
  input  logic s_systemClock,
  input  logic coreRunning,
  ciUnitIf.unit port
);

  logic                     busy;
  logic                     doneReg;
  logic [ciWordWidth-1:0]   usLeft;
  logic [delayTickBits-1:0] tickCount;
  logic                     tickWrap;

  assign tickWrap = (tickCount == delayTickBits'(delayTickCycles - 1));

  always_ff @(posedge s_systemClock or negedge coreRunning) begin
    if (!coreRunning) begin
      busy <= 1'b0;
      doneReg <= 1'b0;
      usLeft <= '0;
      tickCount <= '0;
    end else begin
      doneReg <= 1'b0;
      if (port.start) begin
        if (port.dataA == '0) begin
          doneReg <= 1'b1;  // zero delay answers next cycle.
        end else begin
          busy <= 1'b1;
          usLeft <= port.dataA;
          tickCount <= delayTickBits'(1);  // start cycle is the first tick.
        end
      end else if (busy) begin
        if (tickWrap) begin
          tickCount <= '0;
          usLeft <= usLeft - ciWordWidth'(1);
          if (usLeft == ciWordWidth'(1)) begin
            busy <= 1'b0;
            doneReg <= 1'b1;
          end
        end else begin
          tickCount <= tickCount + delayTickBits'(1);
        end
      end
    end
  end

  assign port.done = doneReg;
  assign port.result = '0;  // delay returns nothing.

  // the CPU blocks on done, so a second start means a lost instruction.
  noStartWhileBusy: assert property (
    @(posedge s_systemClock) disable iff (!coreRunning)
    port.start |-> !busy
  );

endmodule

`default_nettype wire

/* rtl/profileUnit.sv */
`default_nettype none

module profileUnit import ciPkg::*; (
  input  logic s_systemClock,
  input  logic coreRunning,
  input  logic stall,
  input  logic busIdle,
  ciUnitIf.unit port
);

  logic [ciWordWidth-1:0]         counters [profileCounterCount];
  logic [profileCounterCount-1:0] enabled;
  logic [profileCounterCount-1:0] enableMask;
  logic [profileCounterCount-1:0] disableMask;
  logic [profileCounterCount-1:0] clearMask;
  logic [profileCounterCount-1:0] countEvent;
  logic [1:0]                     select;
  logic [ciWordWidth-1:0]         selectedValue;

  // control fields of dataB.
  assign enableMask = port.dataB[2:0];
  assign disableMask = port.dataB[6:4];
  assign clearMask = port.dataB[10:8];

  assign countEvent[profileCycleIndex] = 1'b1;
  assign countEvent[profileStallIndex] = stall;
  assign countEvent[profileIdleIndex] = busIdle;

  // disable wins over enable in the same instruction.
  always_ff @(posedge s_systemClock or negedge coreRunning) begin
    if (!coreRunning) begin
      enabled <= '0;
    end else if (port.start) begin
      enabled <= (enabled | enableMask) & ~disableMask;
    end
  end

  always_ff @(posedge s_systemClock or negedge coreRunning) begin
    if (!coreRunning) begin
      for (int i = 0; i < profileCounterCount; i++) begin
        counters[i] <= '0;
      end
    end else begin
      for (int i = 0; i < profileCounterCount; i++) begin
        if (port.start && clearMask[i]) begin
          counters[i] <= '0;
        end else if (enabled[i] && countEvent[i]) begin
          counters[i] <= counters[i] + ciWordWidth'(1);
        end
      end
    end
  end

  assign select = port.dataA[1:0];

  // index 3 reads as zero.
  always_comb begin
    selectedValue = '0;
    if (select < 2'(profileCounterCount)) begin
      selectedValue = counters[select];
    end
  end

  // answers in the start cycle with the value before this edge.
  assign port.done = port.start;
  assign port.result = port.start ? selectedValue : '0;

endmodule

`default_nettype wire

/* rtl/ciSubsystem.sv */
`default_nettype none

module ciSubsystem import ciPkg::*; (
  input  logic                   s_systemClock,
  input  logic                   s_pllLocked,
  input  logic                   ciStart,
  input  logic [7:0]             ciN,
  input  logic [ciWordWidth-1:0] ciDataA,
  input  logic [ciWordWidth-1:0] ciDataB,
  input  logic                   stall,
  input  logic                   busIdle,
  output logic                   ciDone,
  output logic [ciWordWidth-1:0] ciResult,
  output logic                   peripheralRelease
);

  logic    coreRunning;
  ciOpcode opcode;

  assign opcode = ciOpcode'(ciN);  // any value may arrive here.

  ciUnitIf delayLink ();
  ciUnitIf profileLink ();

  resetSequencer u_resetSequencer (
    .s_systemClock    (s_systemClock),
    .s_pllLocked      (s_pllLocked),
    .coreRunning      (coreRunning),
    .peripheralRelease(peripheralRelease)
  );

  ciDispatcher u_ciDispatcher (
    .s_systemClock(s_systemClock),
    .coreRunning  (coreRunning),
    .ciStart      (ciStart),
    .ciN          (opcode),
    .ciDataA      (ciDataA),
    .ciDataB      (ciDataB),
    .delayPort    (delayLink.dispatcher),
    .profilePort  (profileLink.dispatcher),
    .ciDone       (ciDone),
    .ciResult     (ciResult)
  );

  delayUnit u_delayUnit (
    .s_systemClock(s_systemClock),
    .coreRunning  (coreRunning),
    .port         (delayLink.unit)
  );

  profileUnit u_profileUnit (
    .s_systemClock(s_systemClock),
    .coreRunning  (coreRunning),
    .stall        (stall),
    .busIdle      (busIdle),
    .port         (profileLink.unit)
  );

endmodule

`default_nettype wire

/* tests/ciSubsystemTb.sv */
`default_nettype none

module ciSubsystemTb import ciPkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int clockPeriod = 8;
  localparam int lockLowCycles = 4;
  localparam int holdCycles = 16;
  localparam int microsecondCycles = 75;  // delay ticks per unit of dataA.
  localparam int fieldCount = 7;  // words per vector.
  localparam int maxVectors = 64;
  localparam int unknownWaitCycles = 100;
  localparam int doneSlack = 8;
  localparam logic [31:0] endMarker = 32'hffffffff;

  logic                   s_systemClock;
  logic                   s_pllLocked;
  logic                   ciStart;
  logic [7:0]             ciN;
  logic [ciWordWidth-1:0] ciDataA;
  logic [ciWordWidth-1:0] ciDataB;
  logic                   stall;
  logic                   busIdle;
  logic                   ciDone;
  logic [ciWordWidth-1:0] ciResult;
  logic                   peripheralRelease;

  logic [31:0] stimMem [fieldCount*maxVectors];
  int          vectorCount;
  int          cycleCount;
  int          cycleLimit;
  int          testCount;
  int          failedTests;
  int          checkErrors;
  bit          testFailed;

  ciSubsystem u_dut (
    .s_systemClock    (s_systemClock),
    .s_pllLocked      (s_pllLocked),
    .ciStart          (ciStart),
    .ciN              (ciN),
    .ciDataA          (ciDataA),
    .ciDataB          (ciDataB),
    .stall            (stall),
    .busIdle          (busIdle),
    .ciDone           (ciDone),
    .ciResult         (ciResult),
    .peripheralRelease(peripheralRelease)
  );

  initial s_systemClock = 1'b0;
  always #(clockPeriod / 2) s_systemClock = ~s_systemClock;

  // watchdog.
  always @(posedge s_systemClock) begin
    cycleCount++;
    if (cycleCount > cycleLimit) begin
      $display("run stopped, cycle limit of %0d cycles reached", cycleLimit);
      $display("*** FAILED ***");
      $finish;
    end
  end

  // cycles from start to done or -1 when no done may come.
  function automatic int expectedLatency(input logic [7:0] opcode, input logic [31:0] dataA);
    int latency;
    case (opcode)
      opSwapByte: latency = 0;
      opProfile:  latency = 0;
      opDelay:    latency = (dataA == 0) ? 1 : microsecondCycles * int'(dataA);
      default:    latency = -1;
    endcase
    return latency;
  endfunction

  function automatic string opName(input logic [7:0] opcode);
    string name;
    case (opcode)
      opSwapByte: name = "byte swap";
      opDelay:    name = "delay";
      opProfile:  name = "profile";
      default:    name = "unknown opcode";
    endcase
    return name;
  endfunction

  function automatic int countVectors();
    int count;
    count = 0;
    while (count < maxVectors && stimMem[count*fieldCount] !== endMarker) begin
      count++;
    end
    return count;
  endfunction

  function automatic int runLength();
    int total;
    int index;
    int latency;
    total = lockLowCycles + holdCycles + 4;
    for (index = 0; index < vectorCount; index++) begin
      latency = expectedLatency(stimMem[index*fieldCount][7:0], stimMem[index*fieldCount+1]);
      total += 1 + int'(stimMem[index*fieldCount+5]);
      total += (latency < 0) ? unknownWaitCycles : latency;
    end
    return total + 200;
  endfunction

  task automatic checkValue(input string signalName, input logic [31:0] actual,
                            input logic [31:0] expected);
    assert (actual === expected) else begin
      $display("FAIL %s got 0x%08h expected 0x%08h", signalName, actual, expected);
      checkErrors++;
      testFailed = 1'b1;
    end
  endtask

  task automatic checkFlag(input logic condition, input string what);
    assert (condition === 1'b1) else begin
      $display("error at cycle %0d: %s", cycleCount, what);
      checkErrors++;
      testFailed = 1'b1;
    end
  endtask

  task automatic finishTest(input string label);
    testCount++;
    if (testFailed) begin
      failedTests++;
    end
    $display("test %0d %s: %s", testCount, label, testFailed ? "error" : "ok");
    testFailed = 1'b0;
  endtask

  // outputs settle a quarter period after the falling edge drive.
  task automatic settle();
    #(clockPeriod / 4);
  endtask

  task automatic runResetTest();
    int cycle;
    for (cycle = 0; cycle < lockLowCycles; cycle++) begin
      @(negedge s_systemClock);
      ciStart = (cycle == 1);  // must be ignored.
      ciN = opSwapByte;
      ciDataA = 32'h01020304;
      settle();
      checkFlag(!ciDone, "ciDone rose while s_pllLocked was low");
      checkFlag(!peripheralRelease, "peripheralRelease rose while s_pllLocked was low");
    end
    @(negedge s_systemClock);
    ciStart = 1'b0;
    s_pllLocked = 1'b1;
    for (cycle = 1; cycle <= holdCycles + 2; cycle++) begin
      @(negedge s_systemClock);
      ciStart = (cycle == 5);
      settle();
      checkValue("peripheralRelease", 32'(peripheralRelease),
                 (cycle >= holdCycles) ? 32'd1 : 32'd0);
      if (cycle < holdCycles) begin
        checkFlag(!ciDone, "ciDone answered a start given before release");
      end
    end
    finishTest("reset release");
  endtask

  task automatic runVector(input int index);
    int          base;
    logic [7:0]  opcode;
    logic [31:0] expected;
    int          gapCycles;
    int          latency;
    int          waitLimit;
    int          waited;
    int          i;
    bit          seenDone;
    base = index * fieldCount;
    opcode = stimMem[base][7:0];
    expected = stimMem[base+6];
    gapCycles = int'(stimMem[base+5]);
    latency = expectedLatency(opcode, stimMem[base+1]);
    @(negedge s_systemClock);
    ciN = opcode;
    ciDataA = stimMem[base+1];
    ciDataB = stimMem[base+2];
    stall = stimMem[base+3][0];
    busIdle = stimMem[base+4][0];
    ciStart = 1'b1;
    settle();
    if (latency == 0) begin
      checkFlag(ciDone, "ciDone did not rise in the start cycle");
      checkValue("ciResult", ciResult, expected);
    end else begin
      checkFlag(!ciDone, "ciDone rose in the start cycle of a multi-cycle instruction");
      waitLimit = (latency < 0) ? unknownWaitCycles : latency + doneSlack;
      waited = 0;
      seenDone = 1'b0;
      while (!seenDone && waited < waitLimit) begin
        @(negedge s_systemClock);
        ciStart = 1'b0;
        settle();
        waited++;
        seenDone = ciDone;
      end
      if (latency < 0) begin
        checkFlag(!seenDone, "an unknown opcode produced a ciDone");
      end else begin
        checkFlag(seenDone, "no ciDone arrived before the wait limit");
        checkValue("ciDone latency", 32'(waited), 32'(latency));
        checkValue("ciResult", ciResult, expected);
      end
    end
    for (i = 0; i < gapCycles; i++) begin
      @(negedge s_systemClock);
      ciStart = 1'b0;
      settle();
      checkFlag(!ciDone, "ciDone was high outside an instruction");
      checkValue("ciResult", ciResult, 32'd0);
    end
    finishTest(opName(opcode));
  endtask

  initial begin
    int index;
    s_pllLocked = 1'b0;
    ciStart = 1'b0;
    ciN = 8'd0;
    ciDataA = '0;
    ciDataB = '0;
    stall = 1'b0;
    busIdle = 1'b0;
    cycleCount = 0;
    cycleLimit = 1000;
    testCount = 0;
    failedTests = 0;
    checkErrors = 0;
    testFailed = 1'b0;
    $readmemh("tests/ciStim.mem", stimMem);
    vectorCount = countVectors();
    cycleLimit = runLength();
    assert (vectorCount > 0 && vectorCount < maxVectors) else begin
      $display("the stim file holds no vectors or lacks its end marker");
      checkErrors++;
    end
    runResetTest();
    for (index = 0; index < vectorCount; index++) begin
      runVector(index);
    end
    $display("tests run %0d, tests failed %0d, check errors %0d",
             testCount, failedTests, checkErrors);
    if (failedTests == 0 && checkErrors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sim.f */
rtl/ciPkg.sv
rtl/ciUnitIf.sv
rtl/resetSequencer.sv
rtl/ciDispatcher.sv
rtl/delayUnit.sv
rtl/profileUnit.sv
rtl/ciSubsystem.sv
tests/ciSubsystemTb.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --assert --timing --timescale 1ns/1ps -j 0
TOP       := ciSubsystemTb
FILELIST  := sim.f

BUILD_DIR := obj_dir
SIM_BIN   := $(BUILD_DIR)/V$(TOP)
SIM_LOG   := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(SIM_LOG)
	@grep -qF '*** PASSED ***' $(SIM_LOG)

clean:
	rm -rf $(BUILD_DIR) $(SIM_LOG)

/* tests/ciStim.mem */
// columns: opcode dataA dataB stall busIdle gap expectedResult, all in hex.
// stall and busIdle hold from the start cycle to the next start; ffffffff ends the list.
01 12345678 00000000 0 0 2 78563412
01 12345678 00000001 0 0 2 34127856
01 a1b2c3d4 00000003 0 0 2 b2a1d4c3
06 00000000 00000000 0 0 2 00000000
06 00000001 00000000 0 0 2 00000000
06 00000003 00000000 1 1 2 00000000
2a 00000005 00000000 0 0 2 00000000
01 cafef00d 00000000 0 0 2 0df0feca
0c 00000000 00000005 0 1 a 00000000
0c 00000000 00000000 0 1 5 0000000a
0c 00000002 00000000 1 1 3 00000010
0c 00000001 00000000 1 0 2 00000000
0c 00000002 00000400 0 0 2 00000014
0c 00000002 00000000 0 0 2 00000000
0c 00000000 00000770 0 0 3 0000001d
0c 00000000 00000000 0 0 1 00000000
0c 00000003 00000000 0 0 1 00000000
0c 00000000 00000101 0 0 4 00000000
0c 00000000 00000000 0 0 2 00000004
ffffffff 0 0 0 0 0 0
